// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

   // data word and byte address
   typedef logic [31:0] word_t;
   // word address on the instruction and data ports
   typedef logic [29:0] iaddr_t;
   typedef logic [4:0] reg_idx_t;

   // pc value coming out of reset
   localparam word_t TEXT_START = 32'h0040_0000;

   // primary opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_SLTI  = 6'h0a;
   localparam logic [5:0] OP_SLTIU = 6'h0b;
   localparam logic [5:0] OP_ANDI  = 6'h0c;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_XORI  = 6'h0e;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // funct field of r-type instructions
   localparam logic [5:0] FN_SLL     = 6'h00;
   localparam logic [5:0] FN_SRL     = 6'h02;
   localparam logic [5:0] FN_SRA     = 6'h03;
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADD     = 6'h20;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUB     = 6'h22;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;
   localparam logic [5:0] FN_SLTU    = 6'h2b;

   // no overflow traps, so add and addu share ALU_ADD
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   // control bundle that rides along with each instruction
   typedef struct packed {
      logic    reg_we;
      logic    mem_we;
      logic    mem_rd;
      logic    use_imm;
      logic    is_branch;
      logic    branch_ne;
      logic    is_sys;
      alu_op_e alu_op;
      logic    valid;
   } ctrl_t;

   typedef struct packed {
      word_t    pc_plus4;
      word_t    rs_data;
      word_t    rt_data;
      // already sign or zero extended
      word_t    imm;
      logic [4:0] shamt;
      reg_idx_t dest;
      ctrl_t    ctrl;
   } id_ex_t;

   typedef struct packed {
      word_t    alu_out;
      word_t    store_data;
      reg_idx_t dest;
      ctrl_t    ctrl;
   } ex_mem_t;

   // register file write port
   typedef struct packed {
      word_t    result;
      reg_idx_t dest;
      logic     reg_we;
   } mem_wb_t;

endpackage

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
   input  wire                    clk,
   input  wire                    rst_b,
   input  wire                    stall,
   input  wire                    halted,
   input  wire                    br_taken,
   input  wire  mips_pkg::word_t  br_target,
   input  wire  mips_pkg::word_t  inst,
   output mips_pkg::iaddr_t       inst_addr,
   output mips_pkg::word_t        if_inst,
   output mips_pkg::word_t        if_pc_plus4,
   output logic                   if_valid
);

   mips_pkg::word_t pc;
   mips_pkg::word_t pc_plus4;

   assign pc_plus4  = pc + 32'd4;
   // instruction rom is word addressed
   assign inst_addr = pc[31:2];

   // taken branch wins over both stall and halt
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= mips_pkg::TEXT_START;
      end else if (br_taken) begin
         pc <= br_target;
      end else if (!stall && !halted) begin
         pc <= pc_plus4;
      end
   end

   // fetch/decode register
   // a bubble is an all-zero word with valid low, decoded as a nop
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         if_inst     <= '0;
         if_pc_plus4 <= '0;
         if_valid    <= 1'b0;
      end else if (br_taken || halted) begin
         if_inst     <= '0;
         if_pc_plus4 <= '0;
         if_valid    <= 1'b0;
      end else if (!stall) begin
         if_inst     <= inst;
         if_pc_plus4 <= pc_plus4;
         if_valid    <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
   input  wire                    clk,
   input  wire                    rst_b,
   input  wire  mips_pkg::word_t  if_inst,
   input  wire  mips_pkg::word_t  if_pc_plus4,
   input  wire                    if_valid,
   input  wire                    stall,
   input  wire                    br_taken,
   input  wire  mips_pkg::mem_wb_t wb,
   output mips_pkg::reg_idx_t     src_rs,
   output mips_pkg::reg_idx_t     src_rt,
   output logic                   src_uses_rt,
   output mips_pkg::id_ex_t       id_ex
);

   logic [5:0]         opcode;
   logic [5:0]         funct;
   mips_pkg::reg_idx_t rd;
   logic [15:0]        imm16;
   logic               zero_ext;
   mips_pkg::reg_idx_t dest;
   mips_pkg::ctrl_t    ctrl;
   mips_pkg::word_t    rs_data;
   mips_pkg::word_t    rt_data;
   mips_pkg::word_t    rf [32];

   // instruction fields
   assign opcode = if_inst[31:26];
   assign src_rs = if_inst[25:21];
   assign src_rt = if_inst[20:16];
   assign rd     = if_inst[15:11];
   assign funct  = if_inst[5:0];
   assign imm16  = if_inst[15:0];

   // rt is read by r-type ops, stores and branches
   assign src_uses_rt = (opcode == mips_pkg::OP_RTYPE) || (opcode == mips_pkg::OP_SW) ||
                        (opcode == mips_pkg::OP_BEQ) || (opcode == mips_pkg::OP_BNE);

   // r-type writes rd, everything else writes rt
   assign dest = (opcode == mips_pkg::OP_RTYPE) ? rd : src_rt;

   always_comb begin
      ctrl        = '0;
      ctrl.valid  = if_valid;
      ctrl.alu_op = mips_pkg::ALU_ADD;
      zero_ext    = 1'b0;
      unique case (opcode)
         mips_pkg::OP_RTYPE: begin
            ctrl.reg_we = 1'b1;
            unique case (funct)
               mips_pkg::FN_SUB, mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  ctrl.alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
               mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA:  ctrl.alu_op = mips_pkg::ALU_SRA;
               mips_pkg::FN_ADD, mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SYSCALL: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.is_sys = 1'b1;
               end
               // unknown funct retires as a nop
               default: ctrl.reg_we = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = (opcode == mips_pkg::OP_SLTI) ? mips_pkg::ALU_SLT : mips_pkg::ALU_SLTU;
         end
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
            zero_ext     = 1'b1;
            ctrl.alu_op  = (opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                           (opcode == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR  : mips_pkg::ALU_XOR;
         end
         mips_pkg::OP_LUI: begin
            ctrl.reg_we  = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.alu_op  = mips_pkg::ALU_LUI;
         end
         mips_pkg::OP_LW: begin
            ctrl.reg_we  = 1'b1;
            ctrl.mem_rd  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         mips_pkg::OP_SW: begin
            ctrl.mem_we  = 1'b1;
            ctrl.use_imm = 1'b1;
         end
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
            ctrl.is_branch = 1'b1;
            ctrl.branch_ne = (opcode == mips_pkg::OP_BNE);
            ctrl.alu_op    = mips_pkg::ALU_SUB;
         end
         default: ctrl.reg_we = 1'b0;
      endcase
      // writes to $zero are dropped here, so nops never look like producers
      ctrl.reg_we = ctrl.reg_we & (dest != '0);
   end

   // register file, written at the end of the writeback cycle
   always_ff @(posedge clk) begin
      if (wb.reg_we) begin
         rf[wb.dest] <= wb.result;
      end
   end

   // write-through read, a value in writeback is visible in decode
   assign rs_data = (src_rs == '0) ? '0 :
                    (wb.reg_we && wb.dest == src_rs) ? wb.result : rf[src_rs];
   assign rt_data = (src_rt == '0) ? '0 :
                    (wb.reg_we && wb.dest == src_rt) ? wb.result : rf[src_rt];

   // decode/execute register, bubble on stall or flush
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_ex <= '0;
      end else begin
         id_ex.pc_plus4 <= if_pc_plus4;
         id_ex.rs_data  <= rs_data;
         id_ex.rt_data  <= rt_data;
         id_ex.imm      <= zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
         id_ex.shamt    <= if_inst[10:6];
         id_ex.dest     <= dest;
         id_ex.ctrl     <= (stall || br_taken) ? '0 : ctrl;
      end
   end

   // $zero must never reach the write port with its enable set
   assert property (@(posedge clk) disable iff (!rst_b) wb.reg_we |-> (wb.dest != '0));

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
   input  wire                       clk,
   input  wire                       rst_b,
   input  wire  mips_pkg::reg_idx_t  src_rs,
   input  wire  mips_pkg::reg_idx_t  src_rt,
   input  wire                       src_uses_rt,
   input  wire  mips_pkg::reg_idx_t  ex_dest,
   input  wire                       ex_reg_we,
   input  wire  mips_pkg::reg_idx_t  mem_dest,
   input  wire                       mem_reg_we,
   output logic                      stall
);

   logic       ex_hit;
   logic       mem_hit;
   logic [1:0] cnt_q;
   logic [1:0] cnt_eff;

   // $zero never creates a dependency
   assign ex_hit  = ex_reg_we && ((src_rs != '0 && src_rs == ex_dest) ||
                    (src_uses_rt && src_rt != '0 && src_rt == ex_dest));
   assign mem_hit = mem_reg_we && ((src_rs != '0 && src_rs == mem_dest) ||
                    (src_uses_rt && src_rt != '0 && src_rt == mem_dest));

   // cycles still to stall, counting this one
   // producer in execute needs 2, producer in memory needs 1
   // detection is ignored while a countdown is running
   assign cnt_eff = (cnt_q != 2'd0) ? cnt_q :
                    ex_hit          ? 2'd2  :
                    mem_hit         ? 2'd1  : 2'd0;

   assign stall = (cnt_eff != 2'd0);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         cnt_q <= 2'd0;
      end else if (cnt_eff != 2'd0) begin
         cnt_q <= cnt_eff - 2'd1;
      end
   end

   // bubbles fill execute and memory, so a stall never runs past 2 cycles
   assert property (@(posedge clk) disable iff (!rst_b) not (stall [*3]));

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
   input  wire                      clk,
   input  wire                      rst_b,
   input  wire  mips_pkg::id_ex_t   id_ex,
   output logic                     br_taken,
   output mips_pkg::word_t          br_target,
   output mips_pkg::ex_mem_t        ex_mem
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t op_b;
   mips_pkg::word_t alu_out;
   logic            rs_eq_rt;

   assign op_a = id_ex.rs_data;
   // immediate replaces rt for i-type, loads and stores
   assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rt_data;

   always_comb begin
      unique case (id_ex.ctrl.alu_op)
         mips_pkg::ALU_ADD:  alu_out = op_a + op_b;
         mips_pkg::ALU_SUB:  alu_out = op_a - op_b;
         mips_pkg::ALU_AND:  alu_out = op_a & op_b;
         mips_pkg::ALU_OR:   alu_out = op_a | op_b;
         mips_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
         mips_pkg::ALU_NOR:  alu_out = ~(op_a | op_b);
         mips_pkg::ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
         mips_pkg::ALU_SLTU: alu_out = {31'd0, op_a < op_b};
         // shifts move rt by the shamt field
         mips_pkg::ALU_SLL:  alu_out = op_b << id_ex.shamt;
         mips_pkg::ALU_SRL:  alu_out = op_b >> id_ex.shamt;
         mips_pkg::ALU_SRA:  alu_out = mips_pkg::word_t'($signed(op_b) >>> id_ex.shamt);
         mips_pkg::ALU_LUI:  alu_out = {op_b[15:0], 16'h0000};
         default:            alu_out = '0;
      endcase
   end

   // branch compare always looks at rt, not the immediate
   assign rs_eq_rt  = (id_ex.rs_data == id_ex.rt_data);
   assign br_taken  = id_ex.ctrl.valid && id_ex.ctrl.is_branch &&
                      (rs_eq_rt != id_ex.ctrl.branch_ne);
   assign br_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

   // execute/memory register, no stall reaches this far
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_mem <= '0;
      end else begin
         ex_mem.alu_out    <= alu_out;
         ex_mem.store_data <= id_ex.rt_data;
         ex_mem.dest       <= id_ex.dest;
         ex_mem.ctrl       <= id_ex.ctrl;
      end
   end

   // decode must flush its slot when a branch redirects
   assert property (@(posedge clk) disable iff (!rst_b) br_taken |=> !id_ex.ctrl.valid);

endmodule

`default_nettype wire

// File: src/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
   input  wire                      clk,
   input  wire                      rst_b,
   input  wire  mips_pkg::ex_mem_t  ex_mem,
   input  wire  mips_pkg::word_t    mem_rdata,
   output mips_pkg::iaddr_t         mem_addr,
   output mips_pkg::word_t          mem_wdata,
   output logic                     mem_we,
   output mips_pkg::mem_wb_t        wb,
   output logic                     halted
);

   // word addressed data port
   assign mem_addr  = ex_mem.alu_out[31:2];
   assign mem_wdata = ex_mem.store_data;
   // no stores once the core has halted
   assign mem_we    = ex_mem.ctrl.valid && ex_mem.ctrl.mem_we && !halted;

   // memory/writeback register drives the register file write port
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb <= '0;
      end else begin
         wb.result <= ex_mem.ctrl.mem_rd ? mem_rdata : ex_mem.alu_out;
         wb.dest   <= ex_mem.dest;
         wb.reg_we <= ex_mem.ctrl.valid && ex_mem.ctrl.reg_we && !halted;
      end
   end

   // sticky until reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (ex_mem.ctrl.valid && ex_mem.ctrl.is_sys) begin
         halted <= 1'b1;
      end
   end

   // a word access is either a load or a store, never both
   assert property (@(posedge clk) disable iff (!rst_b)
                    ex_mem.ctrl.valid |-> !(ex_mem.ctrl.mem_we && ex_mem.ctrl.mem_rd));

endmodule

`default_nettype wire

// File: src/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core (
   input  wire                    clk,
   input  wire                    rst_b,
   output mips_pkg::iaddr_t       inst_addr,
   input  wire  mips_pkg::word_t  inst,
   output mips_pkg::iaddr_t       mem_addr,
   output mips_pkg::word_t        mem_wdata,
   output logic                   mem_we,
   input  wire  mips_pkg::word_t  mem_rdata,
   output logic                   halted
);

   mips_pkg::word_t    if_inst;
   mips_pkg::word_t    if_pc_plus4;
   logic               if_valid;
   logic               stall;
   logic               br_taken;
   mips_pkg::word_t    br_target;
   mips_pkg::reg_idx_t src_rs;
   mips_pkg::reg_idx_t src_rt;
   logic               src_uses_rt;
   mips_pkg::id_ex_t   id_ex;
   mips_pkg::ex_mem_t  ex_mem;
   mips_pkg::mem_wb_t  wb;

   fetch_stage i_fetch_stage (
      .clk, .rst_b, .stall, .halted, .br_taken, .br_target, .inst,
      .inst_addr, .if_inst, .if_pc_plus4, .if_valid
   );

   decode_stage i_decode_stage (
      .clk, .rst_b, .if_inst, .if_pc_plus4, .if_valid, .stall, .br_taken, .wb,
      .src_rs, .src_rt, .src_uses_rt, .id_ex
   );

   // producers are taken from the execute and memory pipeline registers
   hazard_unit i_hazard_unit (
      .clk, .rst_b, .src_rs, .src_rt, .src_uses_rt,
      .ex_dest    (id_ex.dest),
      .ex_reg_we  (id_ex.ctrl.reg_we && id_ex.ctrl.valid),
      .mem_dest   (ex_mem.dest),
      .mem_reg_we (ex_mem.ctrl.reg_we && ex_mem.ctrl.valid),
      .stall
   );

   execute_stage i_execute_stage (
      .clk, .rst_b, .id_ex, .br_taken, .br_target, .ex_mem
   );

   memory_stage i_memory_stage (
      .clk, .rst_b, .ex_mem, .mem_rdata, .mem_addr, .mem_wdata, .mem_we, .wb, .halted
   );

endmodule

`default_nettype wire

// File: dv/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model #(
   parameter int MEM_WORDS = 256,
   parameter int ADDR_W    = $clog2(MEM_WORDS)
) (
   input  wire                      clk,
   input  wire  mips_pkg::iaddr_t   inst_addr,
   output mips_pkg::word_t          inst,
   input  wire  mips_pkg::iaddr_t   mem_addr,
   input  wire  mips_pkg::word_t    mem_wdata,
   input  wire                      mem_we,
   output mips_pkg::word_t          mem_rdata,
   // preload port, one word per clock
   input  wire                      ld_we,
   input  wire                      ld_rom,
   input  wire  [ADDR_W-1:0]        ld_idx,
   input  wire  mips_pkg::word_t    ld_data
);

   mips_pkg::word_t  rom [MEM_WORDS];
   mips_pkg::word_t  ram [MEM_WORDS];
   mips_pkg::iaddr_t rom_off;

   // rom word 0 sits at the reset pc
   assign rom_off   = inst_addr - mips_pkg::TEXT_START[31:2];
   assign inst      = rom[rom_off[ADDR_W-1:0]];
   assign mem_rdata = ram[mem_addr[ADDR_W-1:0]];

   always @(posedge clk) begin
      if (ld_we && ld_rom) begin
         rom[ld_idx] <= ld_data;
      end
   end

   // preload wins over a core store
   always @(posedge clk) begin
      if (ld_we && !ld_rom) begin
         ram[ld_idx] <= ld_data;
      end else if (mem_we) begin
         ram[mem_addr[ADDR_W-1:0]] <= mem_wdata;
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

   localparam int MEM_WORDS = 256;
   localparam int ADDR_W    = $clog2(MEM_WORDS);

   logic             clk;
   logic             rst_b;
   mips_pkg::iaddr_t inst_addr;
   mips_pkg::word_t  inst;
   mips_pkg::iaddr_t mem_addr;
   mips_pkg::word_t  mem_wdata;
   logic             mem_we;
   mips_pkg::word_t  mem_rdata;
   logic             halted;
   logic             ld_we;
   logic             ld_rom;
   logic [ADDR_W-1:0] ld_idx;
   mips_pkg::word_t  ld_data;

   integer           seed;
   int               err_cnt;
   int               test_cnt;
   int               fail_cnt;
   longint           cycle_cnt;
   longint           budget;
   mips_pkg::word_t  prog [$];
   mips_pkg::word_t  ram_img [MEM_WORDS];
   // store record is {word address, data}
   logic [61:0]      exp_st [$];
   logic [61:0]      obs_st [$];

   initial clk = 1'b0;
   always #4 clk = ~clk;

   mips_core i_mips_core (
      .clk, .rst_b, .inst_addr, .inst, .mem_addr, .mem_wdata, .mem_we, .mem_rdata, .halted
   );

   tb_mem_model #(.MEM_WORDS(MEM_WORDS)) i_tb_mem_model (
      .clk, .inst_addr, .inst, .mem_addr, .mem_wdata, .mem_we, .mem_rdata,
      .ld_we, .ld_rom, .ld_idx, .ld_data
   );

   // store monitor
   always @(posedge clk) begin
      if (rst_b && mem_we) begin
         obs_st.push_back({mem_addr, mem_wdata});
      end
   end

   // watchdog budget grows with each program that is loaded
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > budget) begin
         $display("watchdog: run did not complete within %0d cycles", budget);
         $display("Finished with errors");
         $finish;
      end
   end

   function automatic mips_pkg::word_t encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] sh);
      return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic mips_pkg::word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // data ram pattern mixes every address bit
   task automatic fill_ram_image();
      foreach (ram_img[i]) begin
         ram_img[i] = 32'h5a00_0000 ^ (mips_pkg::word_t'(i) * 32'h0101_0101);
      end
   endtask

   // sequential instruction-set model that collects the stores of a correct core
   task automatic compute_expected();
      mips_pkg::word_t regs [32];
      mips_pkg::word_t ram_ref [MEM_WORDS];
      mips_pkg::word_t w;
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      mips_pkg::word_t sx;
      mips_pkg::word_t zx;
      mips_pkg::word_t addr;
      mips_pkg::word_t res;
      logic [4:0]      dest;
      logic            wr;
      logic            done;
      int              pc;
      int              steps;
      foreach (regs[i]) regs[i] = '0;
      foreach (ram_ref[i]) ram_ref[i] = ram_img[i];
      exp_st.delete();
      pc    = 0;
      steps = 0;
      done  = 1'b0;
      while (!done && pc < prog.size() && steps < 1000) begin
         w     = prog[pc];
         a     = regs[w[25:21]];
         b     = regs[w[20:16]];
         sx    = {{16{w[15]}}, w[15:0]};
         zx    = {16'h0000, w[15:0]};
         addr  = a + sx;
         res   = '0;
         wr    = 1'b1;
         pc    = pc + 1;
         steps = steps + 1;
         case (w[31:26])
            mips_pkg::OP_RTYPE: begin
               case (w[5:0])
                  mips_pkg::FN_ADD, mips_pkg::FN_ADDU: res = a + b;
                  mips_pkg::FN_SUB, mips_pkg::FN_SUBU: res = a - b;
                  mips_pkg::FN_AND:  res = a & b;
                  mips_pkg::FN_OR:   res = a | b;
                  mips_pkg::FN_XOR:  res = a ^ b;
                  mips_pkg::FN_NOR:  res = ~(a | b);
                  mips_pkg::FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                  mips_pkg::FN_SLTU: res = {31'd0, a < b};
                  mips_pkg::FN_SLL:  res = b << w[10:6];
                  mips_pkg::FN_SRL:  res = b >> w[10:6];
                  mips_pkg::FN_SRA:  res = $signed(b) >>> w[10:6];
                  mips_pkg::FN_SYSCALL: begin
                     wr   = 1'b0;
                     done = 1'b1;
                  end
                  default: wr = 1'b0;
               endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: res = a + sx;
            mips_pkg::OP_SLTI:  res = {31'd0, $signed(a) < $signed(sx)};
            mips_pkg::OP_SLTIU: res = {31'd0, a < sx};
            mips_pkg::OP_ANDI:  res = a & zx;
            mips_pkg::OP_ORI:   res = a | zx;
            mips_pkg::OP_XORI:  res = a ^ zx;
            mips_pkg::OP_LUI:   res = {w[15:0], 16'h0000};
            mips_pkg::OP_LW:    res = ram_ref[addr[ADDR_W+1:2]];
            mips_pkg::OP_SW: begin
               wr = 1'b0;
               exp_st.push_back({addr[31:2], b});
               ram_ref[addr[ADDR_W+1:2]] = b;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
               wr = 1'b0;
               // beq when equal, bne when different
               if ((a == b) != (w[31:26] == mips_pkg::OP_BNE)) begin
                  pc = pc + int'($signed(w[15:0]));
               end
            end
            default: wr = 1'b0;
         endcase
         dest = (w[31:26] == mips_pkg::OP_RTYPE) ? w[15:11] : w[20:16];
         if (wr && dest != 5'd0) begin
            regs[dest] = res;
         end
      end
   endtask

   // rom then ram through the preload port
   task automatic load_memories();
      for (int i = 0; i < 2 * MEM_WORDS; i++) begin
         @(posedge clk);
         ld_we  <= 1'b1;
         ld_rom <= (i < MEM_WORDS);
         ld_idx <= ADDR_W'(i % MEM_WORDS);
         if (i < MEM_WORDS) begin
            ld_data <= (i < prog.size()) ? prog[i] : '0;
         end else begin
            ld_data <= ram_img[i - MEM_WORDS];
         end
      end
      @(posedge clk);
      ld_we <= 1'b0;
   endtask

   task automatic reset_core();
      @(posedge clk);
      rst_b <= 1'b0;
      repeat (3) @(posedge clk);
      obs_st.delete();
      rst_b <= 1'b1;
   endtask

   task automatic run_program(input string name, input bit check_freeze);
      int               errs_before;
      mips_pkg::iaddr_t frozen_addr;
      errs_before = err_cnt;
      budget      = budget + 2 * MEM_WORDS + 4 * prog.size() + 60;
      compute_expected();
      load_memories();
      reset_core();
      while (halted !== 1'b1) @(posedge clk);
      frozen_addr = inst_addr;
      repeat (8) begin
         @(posedge clk);
         if (check_freeze) begin
            assert (halted === 1'b1) else begin
               $display("halt test: halted dropped after it was raised");
               err_cnt++;
            end
            assert (inst_addr == frozen_addr) else begin
               $display("ERR %s inst_addr expected %h actual %h", name, frozen_addr, inst_addr);
               err_cnt++;
            end
         end
      end
      assert (obs_st.size() == exp_st.size()) else begin
         $display("ERR %s store count expected %0d actual %0d", name, exp_st.size(),
                  obs_st.size());
         err_cnt++;
      end
      for (int i = 0; i < exp_st.size() && i < obs_st.size(); i++) begin
         assert (obs_st[i] == exp_st[i]) else begin
            $display("ERR %s store %0d expected %h actual %h", name, i, exp_st[i], obs_st[i]);
            err_cnt++;
         end
      end
      test_cnt++;
      if (err_cnt != errs_before) begin
         fail_cnt++;
      end
      $display("test %s: %s", name, (err_cnt == errs_before) ? "PASS" : "FAIL");
   endtask

   initial begin
      logic [5:0]  r_fns [13];
      logic [5:0]  i_ops [8];
      logic [15:0] off;
      seed      = 11106;
      err_cnt   = 0;
      test_cnt  = 0;
      fail_cnt  = 0;
      cycle_cnt = 0;
      budget    = 100;
      rst_b     = 1'b0;
      ld_we     = 1'b0;
      ld_rom    = 1'b0;
      ld_idx    = '0;
      ld_data   = '0;
      r_fns = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
                mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
                mips_pkg::FN_SLT, mips_pkg::FN_SLTU, mips_pkg::FN_SLL, mips_pkg::FN_SRL,
                mips_pkg::FN_SRA};
      i_ops = '{mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
                mips_pkg::OP_XORI, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_LUI};

      // reset values, core stays in reset until the first program is loaded
      repeat (3) @(posedge clk);
      assert (halted == 1'b0) else begin
         $display("ERR reset halted expected %b actual %b", 1'b0, halted);
         err_cnt++;
      end
      assert (mem_we == 1'b0) else begin
         $display("ERR reset mem_we expected %b actual %b", 1'b0, mem_we);
         err_cnt++;
      end
      assert (inst_addr == mips_pkg::TEXT_START[31:2]) else begin
         $display("ERR reset inst_addr expected %h actual %h",
                  mips_pkg::TEXT_START[31:2], inst_addr);
         err_cnt++;
      end
      test_cnt++;
      if (err_cnt != 0) begin
         fail_cnt++;
      end
      $display("test reset: %s", (err_cnt == 0) ? "PASS" : "FAIL");

      // alu test with random operands from ram words 0 and 1
      fill_ram_image();
      ram_img[0] = $random(seed);
      ram_img[1] = $random(seed);
      prog.delete();
      prog.push_back(encode_i(mips_pkg::OP_LW, 5'd0, 5'd1, 16'h0000));
      prog.push_back(encode_i(mips_pkg::OP_LW, 5'd0, 5'd2, 16'h0004));
      off = 16'h0100;
      foreach (r_fns[k]) begin
         prog.push_back(encode_r(r_fns[k], 5'd1, 5'd2, 5'd3, 5'($random(seed))));
         prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd3, off));
         off = off + 16'd4;
      end
      foreach (i_ops[k]) begin
         prog.push_back(encode_i(i_ops[k], 5'd1, 5'd3, 16'($random(seed))));
         prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd3, off));
         off = off + 16'd4;
      end
      prog.push_back(encode_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("alu", 1'b0)

;

      // raw test with producers one and two slots ahead of the consumer
      // xor meets addu in memory, the other consumers meet their producer in execute
      fill_ram_image();
      prog.delete();
      prog.push_back(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'($random(seed))));
      prog.push_back(encode_r(mips_pkg::FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
      prog.push_back(encode_i(mips_pkg::OP_ORI, 5'd0, 5'd5, 16'($random(seed))));
      prog.push_back(encode_r(mips_pkg::FN_XOR, 5'd2, 5'd1, 5'd3, 5'd0));
      prog.push_back(encode_r(mips_pkg::FN_SUBU, 5'd3, 5'd5, 5'd6, 5'd0));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd6, 16'h0140));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd2, 16'h0144));
      prog.push_back(encode_r(mips_pkg::FN_SLL, 5'd0, 5'd6, 5'd7, 5'd3));
      prog.push_back(encode_i(mips_pkg::OP_LW, 5'd0, 5'd8, 16'h0144));
      prog.push_back(encode_r(mips_pkg::FN_ADDU, 5'd7, 5'd8, 5'd9, 5'd0));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd9, 16'h0148));
      prog.push_back(encode_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("raw", 1'b0);

      // branch test covers taken and not taken beq and bne
      prog.delete();
      prog.push_back(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd5));
      prog.push_back(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'd5));
      prog.push_back(encode_i(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd2));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0200));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0204));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd2, 16'h0208));
      prog.push_back(encode_i(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'd1));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h020c));
      prog.push_back(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd3, 16'd6));
      prog.push_back(encode_i(mips_pkg::OP_BNE, 5'd1, 5'd3, 16'd1));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd3, 16'h0210));
      prog.push_back(encode_i(mips_pkg::OP_BEQ, 5'd1, 5'd3, 16'd1));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd3, 16'h0214));
      prog.push_back(encode_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("branch", 1'b0);

      // load after store to the same word
      prog.delete();
      prog.push_back(encode_i(mips_pkg::OP_LUI, 5'd0, 5'd1, 16'($random(seed))));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0300));
      prog.push_back(encode_i(mips_pkg::OP_LW, 5'd0, 5'd2, 16'h0300));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd2, 16'h0304));
      prog.push_back(encode_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      run_program("load", 1'b0);

      // stores behind the syscall must not reach memory
      prog.delete();
      prog.push_back(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd9));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0380));
      prog.push_back(encode_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0384));
      prog.push_back(encode_i(mips_pkg::OP_SW, 5'd0, 5'd1, 16'h0388));
      run_program("halt", 1'b1);

      $display("tests run %0d, tests failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: mips_pipe.f
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
dv/tb_mem_model.sv
dv/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mips_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mips_core \
   -f mips_pipe.f -o tb_mips_core > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_mips_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" sim.log; then
   exit 1
fi
exit 0
